/* common/sprite_pkg.sv */
package sprite_pkg;

    // Bus word address, line buffer index and line number widths
    localparam int BUS_ADDR_W    = 15;
    localparam int LINEBUF_IDX_W = 10;
    localparam int LINE_IDX_W    = 9;

    // Sprite collision mask width
    localparam int COLL_W        = 4;

    ////////////////////////////////////////////////////////////
    // Attribute word with two views selected by the index LSB
    ////////////////////////////////////////////////////////////
    typedef union packed {
        // Select 0
        struct packed {
            logic [5:0]  rsvd_hi;
            logic [9:0]  x;
            logic        mode;
            logic [2:0]  rsvd_lo;
            logic [11:0] addr;
        } lo;

        // Select 1
        struct packed {
            logic [1:0]  height;
            logic [1:0]  width;
            logic [3:0]  pal_offset;
            logic [3:0]  coll_mask;
            logic [1:0]  z;
            logic        vflip;
            logic        hflip;
            logic [5:0]  rsvd;
            logic [9:0]  y;
        } hi;
    } sprite_attr_u;

    // Size code to index of the last pixel
    function automatic logic [5:0] size_last_pixel(input logic [1:0] code);
        logic [5:0] last;
        case (code)
            2'd0:    last = 6'd7;
            2'd1:    last = 6'd15;
            2'd2:    last = 6'd31;
            default: last = 6'd63;
        endcase
        return last;
    endfunction

endpackage

/* design/collision_tracker.sv */
`timescale 1ns/1ps

module collision_tracker import sprite_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_done,
    input  logic              render_valid,
    input  logic [COLL_W-1:0] pixel_collision,
    output logic [COLL_W-1:0] collisions,
    output logic              sprcol_irq
);

    logic [COLL_W-1:0] frame_acc_r;

    assign sprcol_irq = frame_done && (frame_acc_r != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_acc_r <= '0;
            collisions  <= '0;
        end else if (frame_done) begin
            // Publish and start a new frame
            collisions  <= frame_acc_r;
            frame_acc_r <= '0;
        end else if (render_valid) begin
            frame_acc_r <= frame_acc_r | pixel_collision;
        end
    end

endmodule

/* design/sprite_renderer.sv */
`timescale 1ns/1ps

module sprite_renderer import sprite_pkg::*; #(
    parameter int SPRITE_IDX_W = 7,
    parameter int VISIBLE_W    = 640
) (
    input  logic                     clk,
    input  logic                     rst,

    // Composer
    input  logic [LINE_IDX_W-1:0]    line_idx,
    input  logic                     line_render_start,
    input  logic                     frame_done,

    // Video memory bus
    output logic [BUS_ADDR_W-1:0]    bus_addr,
    output logic                     bus_strobe,
    input  logic [31:0]              bus_rddata,
    input  logic                     bus_ack,

    // Attribute RAM
    output logic [SPRITE_IDX_W:0]    sprite_idx,
    input  sprite_attr_u             sprite_attr,

    // Line buffer
    output logic [LINEBUF_IDX_W-1:0] linebuf_rdidx,
    input  logic [15:0]              linebuf_rddata,
    output logic [LINEBUF_IDX_W-1:0] linebuf_wridx,
    output logic [15:0]              linebuf_wrdata,
    output logic                     linebuf_wren,

    // Collision status
    output logic [COLL_W-1:0]        collisions,
    output logic                     sprcol_irq
);

    // Latched sprite fields
    logic                     start_render;
    logic [11:0]              spr_addr;
    logic                     spr_mode;
    logic [LINEBUF_IDX_W-1:0] spr_x;
    logic [5:0]               spr_line;
    logic                     spr_hflip;
    logic [1:0]               spr_z;
    logic [COLL_W-1:0]        spr_coll_mask;
    logic [3:0]               spr_pal_offset;
    logic [1:0]               spr_width;

    // Renderer to pixel path
    logic                     render_busy;
    logic [31:0]              render_word;
    logic [2:0]               pix_pos;
    logic                     render_pixel;
    logic                     render_valid;
    logic [COLL_W-1:0]        pixel_collision;

    sprite_search #(
        .SPRITE_IDX_W (SPRITE_IDX_W)
    ) u_sprite_search (
        .clk               (clk),
        .rst               (rst),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .sprite_attr       (sprite_attr),
        .render_busy       (render_busy),
        .sprite_idx        (sprite_idx),
        .start_render      (start_render),
        .spr_addr          (spr_addr),
        .spr_mode          (spr_mode),
        .spr_x             (spr_x),
        .spr_line          (spr_line),
        .spr_hflip         (spr_hflip),
        .spr_z             (spr_z),
        .spr_coll_mask     (spr_coll_mask),
        .spr_pal_offset    (spr_pal_offset),
        .spr_width         (spr_width)
    );

    line_render u_line_render (
        .clk               (clk),
        .rst               (rst),
        .line_render_start (line_render_start),
        .start_render      (start_render),
        .spr_addr          (spr_addr),
        .spr_mode          (spr_mode),
        .spr_x             (spr_x),
        .spr_line          (spr_line),
        .spr_hflip         (spr_hflip),
        .spr_width         (spr_width),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .render_pixel      (render_pixel),
        .bus_addr          (bus_addr),
        .bus_strobe        (bus_strobe),
        .render_busy       (render_busy),
        .render_word       (render_word),
        .pix_pos           (pix_pos),
        .linebuf_rdidx     (linebuf_rdidx),
        .linebuf_wridx     (linebuf_wridx),
        .linebuf_wren      (linebuf_wren),
        .render_valid      (render_valid)
    );

    pixel_compose #(
        .VISIBLE_W (VISIBLE_W)
    ) u_pixel_compose (
        .render_word     (render_word),
        .pix_pos         (pix_pos),
        .spr_mode        (spr_mode),
        .spr_z           (spr_z),
        .spr_coll_mask   (spr_coll_mask),
        .spr_pal_offset  (spr_pal_offset),
        .linebuf_rddata  (linebuf_rddata),
        .linebuf_wridx   (linebuf_wridx),
        .linebuf_wrdata  (linebuf_wrdata),
        .render_pixel    (render_pixel),
        .pixel_collision (pixel_collision)
    );

    collision_tracker u_collision_tracker (
        .clk             (clk),
        .rst             (rst),
        .frame_done      (frame_done),
        .render_valid    (render_valid),
        .pixel_collision (pixel_collision),
        .collisions      (collisions),
        .sprcol_irq      (sprcol_irq)
    );

endmodule

/* line_render/line_render.sv */
`timescale 1ns/1ps

module line_render import sprite_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     line_render_start,
    input  logic                     start_render,
    input  logic [11:0]              spr_addr,
    input  logic                     spr_mode,
    input  logic [LINEBUF_IDX_W-1:0] spr_x,
    input  logic [5:0]               spr_line,
    input  logic                     spr_hflip,
    input  logic [1:0]               spr_width,
    input  logic [31:0]              bus_rddata,
    input  logic                     bus_ack,
    input  logic                     render_pixel,
    output logic [BUS_ADDR_W-1:0]    bus_addr,
    output logic                     bus_strobe,
    output logic                     render_busy,
    output logic [31:0]              render_word,
    output logic [2:0]               pix_pos,
    output logic [LINEBUF_IDX_W-1:0] linebuf_rdidx,
    output logic [LINEBUF_IDX_W-1:0] linebuf_wridx,
    output logic                     linebuf_wren,
    output logic                     render_valid
);

    localparam logic [1:0] R_IDLE       = 2'd0;
    localparam logic [1:0] R_WAIT_FETCH = 2'd1;
    localparam logic [1:0] R_RENDER     = 2'd2;

    logic [1:0]               state_r, state_next;
    logic [5:0]               xcnt_r, xcnt_next;
    logic [LINEBUF_IDX_W-1:0] idx_r, idx_next;
    logic                     strobe_r, strobe_next;
    logic                     fetch;

    logic [5:0]               width_last;
    logic [5:0]               flip_next;
    logic [2:0]               word_shift;
    logic [5:0]               word_sel;
    logic [5:0]               word_mask;
    logic [BUS_ADDR_W-1:0]    line_off;
    logic [BUS_ADDR_W-1:0]    line_addr;
    logic                     word_end;

    ////////////////////////////////////////////////////////////
    // Word address of the next pixel
    ////////////////////////////////////////////////////////////
    assign width_last = size_last_pixel(spr_width);
    assign flip_next  = spr_hflip ? ~xcnt_next : xcnt_next;
    assign pix_pos    = spr_hflip ? ~xcnt_r[2:0] : xcnt_r[2:0];

    // Words per sprite line are 2^(width + mode)
    assign word_shift = {1'b0, spr_width} + {2'b0, spr_mode};
    assign word_sel   = spr_mode ? {2'b0, flip_next[5:2]} : {3'b0, flip_next[5:3]};
    assign word_mask  = spr_mode ? width_last >> 2 : width_last >> 3;
    assign line_off   = BUS_ADDR_W'(spr_line) << word_shift;
    assign line_addr  = {spr_addr, 3'b0} + (line_off | BUS_ADDR_W'(word_sel & word_mask));

    // Last pixel of the held word
    assign word_end   = spr_mode ? (xcnt_r[1:0] == 2'd3) : (xcnt_r[2:0] == 3'd7);

    always_comb begin
        state_next  = state_r;
        xcnt_next   = xcnt_r;
        idx_next    = idx_r;
        strobe_next = strobe_r;
        fetch       = 1'b0;

        case (state_r)
            R_IDLE: begin
                if (start_render) begin
                    idx_next    = spr_x;
                    fetch       = 1'b1;
                    strobe_next = 1'b1;
                    state_next  = R_WAIT_FETCH;
                end
            end

            R_WAIT_FETCH: begin
                if (bus_ack) begin
                    strobe_next = 1'b0;
                    state_next  = R_RENDER;
                end
            end

            R_RENDER: begin
                xcnt_next = xcnt_r + 6'd1;
                idx_next  = idx_r + 1'b1;
                if (word_end) begin
                    if (xcnt_r == width_last) begin
                        xcnt_next  = 6'd0;
                        state_next = R_IDLE;
                    end else begin
                        fetch       = 1'b1;
                        strobe_next = 1'b1;
                        state_next  = R_WAIT_FETCH;
                    end
                end
            end

            default: begin
                state_next = R_IDLE;
            end
        endcase

        // Abort on a new line
        if (line_render_start) begin
            state_next  = R_IDLE;
            xcnt_next   = 6'd0;
            strobe_next = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r  <= R_IDLE;
            xcnt_r   <= 6'd0;
            idx_r    <= '0;
            strobe_r <= 1'b0;
        end else begin
            state_r  <= state_next;
            xcnt_r   <= xcnt_next;
            idx_r    <= idx_next;
            strobe_r <= strobe_next;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            bus_addr <= line_addr;
        end
        if (state_r == R_WAIT_FETCH && bus_ack) begin
            render_word <= bus_rddata;
        end
    end

    // Strobe drops in the ack cycle
    assign bus_strobe    = strobe_r && !bus_ack;
    assign linebuf_rdidx = idx_next;
    assign linebuf_wridx = idx_r;
    assign render_valid  = state_r == R_RENDER;
    assign linebuf_wren  = render_valid && render_pixel;
    assign render_busy   = start_render || (state_r != R_IDLE);

endmodule

/* line_render/pixel_compose.sv */
`timescale 1ns/1ps

module pixel_compose import sprite_pkg::*; #(
    parameter int VISIBLE_W = 640
) (
    input  logic [31:0]              render_word,
    input  logic [2:0]               pix_pos,
    input  logic                     spr_mode,
    input  logic [1:0]               spr_z,
    input  logic [COLL_W-1:0]        spr_coll_mask,
    input  logic [3:0]               spr_pal_offset,
    input  logic [15:0]              linebuf_rddata,
    input  logic [LINEBUF_IDX_W-1:0] linebuf_wridx,
    output logic [15:0]              linebuf_wrdata,
    output logic                     render_pixel,
    output logic [COLL_W-1:0]        pixel_collision
);

    logic [7:0]        byte_4bpp;
    logic [3:0]        nibble;
    logic [7:0]        byte_8bpp;
    logic [7:0]        color;
    logic              opaque;
    logic              dest_clear;
    logic [COLL_W-1:0] dest_mask;

    // High nibble is the left pixel of each byte
    assign byte_4bpp = render_word[8 * pix_pos[2:1] +: 8];
    assign nibble    = pix_pos[0] ? byte_4bpp[3:0] : byte_4bpp[7:4];
    assign byte_8bpp = render_word[8 * pix_pos[1:0] +: 8];

    always_comb begin
        if (spr_mode) begin
            color = byte_8bpp;
        end else if (nibble != 4'd0) begin
            color = {spr_pal_offset, nibble};
        end else begin
            color = 8'd0;
        end
    end

    assign opaque     = color != 8'd0;
    assign dest_clear = linebuf_rddata[7:0] == 8'd0;
    assign dest_mask  = linebuf_rddata[15 -: COLL_W];

    // Depth test against the pixel already in the line buffer
    assign render_pixel   = opaque && ((spr_z > linebuf_rddata[9:8]) || dest_clear);
    assign linebuf_wrdata = {dest_mask | spr_coll_mask, 2'b00, spr_z, color};

    // Only the visible window counts
    assign pixel_collision = (opaque && spr_coll_mask != '0 && linebuf_wridx < VISIBLE_W) ?
                             (dest_mask & ~spr_coll_mask) : '0;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the sprite renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sprite_renderer -f src.f -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1

/* sprite_search/sprite_search.sv */
`timescale 1ns/1ps

module sprite_search import sprite_pkg::*; #(
    parameter int SPRITE_IDX_W = 7
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [LINE_IDX_W-1:0]    line_idx,
    input  logic                     line_render_start,
    input  sprite_attr_u             sprite_attr,
    input  logic                     render_busy,
    output logic [SPRITE_IDX_W:0]    sprite_idx,
    output logic                     start_render,
    output logic [11:0]              spr_addr,
    output logic                     spr_mode,
    output logic [LINEBUF_IDX_W-1:0] spr_x,
    output logic [5:0]               spr_line,
    output logic                     spr_hflip,
    output logic [1:0]               spr_z,
    output logic [COLL_W-1:0]        spr_coll_mask,
    output logic [3:0]               spr_pal_offset,
    output logic [1:0]               spr_width
);

    localparam logic [1:0] S_FIND  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]            state_r, state_next;
    logic [SPRITE_IDX_W:0] slot_r, slot_next;
    logic                  start_next;
    logic                  save_hi;
    logic                  save_lo;

    logic [5:0]            height_last;
    logic [9:0]            ydiff;
    logic                  on_line;
    logic                  enabled;
    logic [5:0]            line_sel;

    // Hi view in FIND, lo view in START
    assign sprite_idx = {slot_r[SPRITE_IDX_W-1:0], state_r != S_START};

    ////////////////////////////////////////////////////////////
    // Line range test on the hi view
    ////////////////////////////////////////////////////////////
    assign height_last = size_last_pixel(sprite_attr.hi.height);
    assign ydiff       = 10'(line_idx) - sprite_attr.hi.y;
    // Lines above y wrap to a large difference
    assign on_line     = ydiff <= {4'b0, height_last};
    assign enabled     = sprite_attr.hi.z != 2'd0;
    assign line_sel    = sprite_attr.hi.vflip ? height_last - ydiff[5:0] : ydiff[5:0];

    always_comb begin
        state_next = state_r;
        slot_next  = slot_r;
        start_next = 1'b0;
        save_hi    = 1'b0;
        save_lo    = 1'b0;

        case (state_r)
            S_FIND: begin
                if (slot_r[SPRITE_IDX_W]) begin
                    state_next = S_DONE;
                end else if (enabled && on_line) begin
                    // Hold the hit until the renderer is free
                    if (!render_busy) begin
                        save_hi    = 1'b1;
                        state_next = S_START;
                    end
                end else begin
                    slot_next = slot_r + 1'b1;
                end
            end

            S_START: begin
                save_lo    = 1'b1;
                start_next = 1'b1;
                slot_next  = slot_r + 1'b1;
                state_next = S_FIND;
            end

            default: begin
            end
        endcase

        // New line restarts at slot 0
        if (line_render_start) begin
            state_next = S_FIND;
            slot_next  = '0;
            start_next = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r      <= S_FIND;
            slot_r       <= '0;
            start_render <= 1'b0;
        end else begin
            state_r      <= state_next;
            slot_r       <= slot_next;
            start_render <= start_next;
        end
    end

    // Chosen sprite fields
    always_ff @(posedge clk) begin
        if (save_hi) begin
            spr_line       <= line_sel;
            spr_hflip      <= sprite_attr.hi.hflip;
            spr_z          <= sprite_attr.hi.z;
            spr_coll_mask  <= sprite_attr.hi.coll_mask;
            spr_pal_offset <= sprite_attr.hi.pal_offset;
            spr_width      <= sprite_attr.hi.width;
        end
        if (save_lo) begin
            spr_addr <= sprite_attr.lo.addr;
            spr_mode <= sprite_attr.lo.mode;
            spr_x    <= sprite_attr.lo.x;
        end
    end

endmodule

/* src.f */
+incdir+tb
common/sprite_pkg.sv
sprite_search/sprite_search.sv
line_render/line_render.sv
line_render/pixel_compose.sv
design/collision_tracker.sv
design/sprite_renderer.sv
tb/tb_sprite_renderer.sv

/* tb/sprite_ref_model.svh */
// Renders one line into ref_lb in slot order and adds the line's collisions
// to ref_frame_coll; bound is the cycle budget for the DUT
task automatic ref_render_line(input int line, output int bound);
    sprite_attr_u hi;
    sprite_attr_u lo;
    int           d;
    int           hl;
    int           wl;
    int           fx;
    int           wa;
    logic [7:0]   b;
    logic [3:0]   nib;
    logic [7:0]   color;
    logic [15:0]  dest;
    logic [31:0]  w;
    logic [9:0]   idx;
    for (int i = 0; i < 1024; i++) begin
        ref_lb[i] = '0;
    end
    bound = 2 * 128 + 8;
    for (int s = 0; s < 128; s++) begin
        hi = attr_mem[2 * s + 1];
        lo = attr_mem[2 * s];
        hl = (8 << hi.hi.height) - 1;
        // Lines above y wrap to a large distance
        d  = (line - int'(hi.hi.y)) & 1023;
        if (hi.hi.z != 2'd0 && d <= hl) begin
            if (hi.hi.vflip) begin
                d = hl - d;
            end
            wl    = (8 << hi.hi.width) - 1;
            bound = bound + wl + 5 + ((wl + 1) / (lo.lo.mode ? 4 : 8)) * (ACK_MAX + 2);
            for (int xc = 0; xc <= wl; xc++) begin
                fx = hi.hi.hflip ? wl - xc : xc;
                wa = (int'(lo.lo.addr) * 8 + (d << (int'(hi.hi.width) + int'(lo.lo.mode)))
                      + (fx >> (lo.lo.mode ? 2 : 3))) & 32'h7fff;
                w  = vmem[wa];
                if (lo.lo.mode) begin
                    color = w[8 * (fx % 4) +: 8];
                end else begin
                    b     = w[8 * ((fx % 8) / 2) +: 8];
                    nib   = (fx % 2 == 1) ? b[3:0] : b[7:4];
                    color = (nib == 4'd0) ? 8'd0 : {hi.hi.pal_offset, nib};
                end
                idx  = 10'(int'(lo.lo.x) + xc);
                dest = ref_lb[idx];
                if (color != 8'd0 && hi.hi.coll_mask != '0 && int'(idx) < VISIBLE_W) begin
                    ref_frame_coll = ref_frame_coll | (dest[15:12] & ~hi.hi.coll_mask);
                end
                if (color != 8'd0 && (hi.hi.z > dest[9:8] || dest[7:0] == 8'd0)) begin
                    ref_lb[idx] = {dest[15:12] | hi.hi.coll_mask, 2'b00, hi.hi.z, color};
                end
            end
        end
    end
endtask

/* tb/tb_sprite_renderer.sv */
`timescale 1ns/1ps

module tb_sprite_renderer import sprite_pkg::*; ();

    localparam int     CLK_PERIOD     = 20;
    localparam int     VISIBLE_W      = 640;
    localparam int     ACK_MAX        = 6;
    localparam int     NUM_LINES      = 67;
    // Worst line has every slot hit by the widest 8 bpp sprite
    localparam int     LINE_BOUND_MAX = 2 * 128 + 128 * (64 + 16 * (ACK_MAX + 2) + 4);
    localparam longint WATCHDOG_NS    = longint'(NUM_LINES) * LINE_BOUND_MAX * 2 * CLK_PERIOD;
    localparam logic [31:0] SEED      = 32'h475bb553;

    logic                     clk;
    logic                     rst;
    logic [LINE_IDX_W-1:0]    line_idx;
    logic                     line_render_start;
    logic                     frame_done;
    logic [BUS_ADDR_W-1:0]    bus_addr;
    logic                     bus_strobe;
    logic [31:0]              bus_rddata = '0;
    logic                     bus_ack = 1'b0;
    logic [7:0]               sprite_idx;
    sprite_attr_u             sprite_attr;
    logic [LINEBUF_IDX_W-1:0] linebuf_rdidx;
    logic [15:0]              linebuf_rddata = '0;
    logic [LINEBUF_IDX_W-1:0] linebuf_wridx;
    logic [15:0]              linebuf_wrdata;
    logic                     linebuf_wren;
    logic [COLL_W-1:0]        collisions;
    logic                     sprcol_irq;

    sprite_attr_u      attr_mem [256];
    logic [31:0]       vmem [32768];
    logic [15:0]       linebuf [1024];
    logic [15:0]       ref_lb [1024];
    logic [COLL_W-1:0] ref_frame_coll;
    logic              lb_clear;
    logic [31:0]       scene_lfsr = SEED;
    logic [31:0]       delay_lfsr = SEED;
    logic              ack_pending = 1'b0;
    logic [2:0]        ack_wait = 3'd0;
    int                errors = 0;
    int                err_mark;
    int                tests_run = 0;
    int                tests_failed = 0;
    string             cur_test;

    sprite_renderer u_sprite_renderer (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = st[31] ^ st[21] ^ st[1] ^ st[0];
            st = {st[30:0], fb};
            r  = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] rnd(input int n);
        return take_bits(scene_lfsr, n);
    endfunction

    // Every address gets its own word with some nibbles cleared
    function automatic logic [31:0] fill_word(input int a);
        logic [31:0] w;
        w = (32'(a) * 32'h9e3779b1) ^ (32'(a) << 17);
        if ((a & 4) != 0) begin
            w = w & 32'hff00f0f0;
        end
        return w;
    endfunction

    `include "sprite_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign sprite_attr = attr_mem[sprite_idx];

    // Line buffer with read data registered from the next index
    always @(posedge clk) begin
        linebuf_rddata <= linebuf[linebuf_rdidx];
        if (lb_clear) begin
            for (int i = 0; i < 1024; i++) begin
                linebuf[i] <= '0;
            end
        end else if (linebuf_wren) begin
            linebuf[linebuf_wridx] <= linebuf_wrdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Video memory bus with random ack delay
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (bus_ack && bus_strobe) begin
            errors++;
            $display("bus_strobe is high in an ack cycle at %0t", $time);
        end
        if (rst) begin
            bus_ack     <= 1'b0;
            ack_pending <= 1'b0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (!bus_strobe) begin
            ack_pending <= 1'b0;
        end else if (!ack_pending) begin
            ack_pending <= 1'b1;
            ack_wait    <= 3'(take_bits(delay_lfsr, 2)) + 3'd1;
        end else if (ack_wait == 3'd1) begin
            bus_ack     <= 1'b1;
            bus_rddata  <= vmem[bus_addr];
            ack_pending <= 1'b0;
        end else begin
            ack_wait <= ack_wait - 3'd1;
        end
    end

    task automatic check_linebuf(input int idx, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s linebuf[%0d] expected %h actual %h", cur_test, idx, exp, act);
        end
    endtask

    task automatic check_collisions(input logic [COLL_W-1:0] exp, input logic [COLL_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s collisions expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s sprcol_irq expected %b actual %b", cur_test, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - err_mark);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    task automatic clear_scene();
        for (int i = 0; i < 256; i++) begin
            attr_mem[i] = '0;
        end
    endtask

    // Random sprite that usually covers the given line
    task automatic random_sprite(input int slot, input int line, input int x_base);
        sprite_attr_u hi;
        sprite_attr_u lo;
        hi = '0;
        lo = '0;
        hi.hi.height     = 2'(rnd(2));
        hi.hi.width      = 2'(rnd(2));
        hi.hi.pal_offset = 4'(rnd(4));
        hi.hi.coll_mask  = 4'(rnd(4));
        hi.hi.z          = 2'(rnd(2));
        hi.hi.hflip      = 1'(rnd(1));
        hi.hi.vflip      = 1'(rnd(1));
        hi.hi.y          = 10'(line - int'(rnd(6)) % (8 << hi.hi.height));
        lo.lo.addr       = 12'(rnd(12));
        lo.lo.mode       = 1'(rnd(1));
        lo.lo.x          = 10'(x_base + int'(rnd(6)));
        attr_mem[2 * slot + 1] = hi;
        attr_mem[2 * slot]     = lo;
    endtask

    task automatic run_line(input int line);
        int bound;
        @(posedge clk);
        lb_clear <= 1'b1;
        @(posedge clk);
        lb_clear <= 1'b0;
        ref_render_line(line, bound);
        line_idx          <= LINE_IDX_W'(line);
        line_render_start <= 1'b1;
        @(posedge clk);
        line_render_start <= 1'b0;
        repeat (bound) @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < 1024; i++) begin
            check_linebuf(i, ref_lb[i], linebuf[i]);
        end
    endtask

    task automatic end_frame();
        logic [COLL_W-1:0] exp;
        exp = ref_frame_coll;
        @(posedge clk);
        frame_done <= 1'b1;
        @(negedge clk);
        check_irq(exp != '0, sprcol_irq);
        @(posedge clk);
        frame_done <= 1'b0;
        @(negedge clk);
        check_irq(1'b0, sprcol_irq);
        check_collisions(exp, collisions);
        ref_frame_coll = '0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int s;
        int y;
        int hl;
        rst               = 1'b1;
        line_idx          = '0;
        line_render_start = 1'b0;
        frame_done        = 1'b0;
        lb_clear          = 1'b0;
        ref_frame_coll    = '0;
        clear_scene();
        for (int a = 0; a < 32768; a++) begin
            vmem[a] = fill_word(a);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        if (bus_strobe !== 1'b0 || linebuf_wren !== 1'b0 || sprcol_irq !== 1'b0) begin
            errors++;
            $display("outputs are not idle after reset");
        end
        check_collisions('0, collisions);
        end_test();

        begin_test("single_sprite");
        for (int k = 0; k < 8; k++) begin
            clear_scene();
            s = int'(rnd(7));
            random_sprite(s, 100, int'(rnd(10)));
            attr_mem[2 * s + 1].hi.z     = 2'(k % 3 + 1);
            attr_mem[2 * s + 1].hi.hflip = 1'b0;
            attr_mem[2 * s + 1].hi.vflip = 1'b0;
            attr_mem[2 * s].lo.mode      = 1'(k % 2);
            run_line(100);
        end
        end_frame();
        end_test();

        begin_test("flip");
        for (int k = 0; k < 6; k++) begin
            clear_scene();
            random_sprite(5, 200, int'(rnd(9)));
            attr_mem[11].hi.z     = 2'd3;
            attr_mem[11].hi.hflip = 1'(k % 2);
            attr_mem[11].hi.vflip = 1'((k / 2) % 2);
            y  = int'(attr_mem[11].hi.y);
            hl = (8 << attr_mem[11].hi.height) - 1;
            // Just above, first, middle, last and just below
            run_line(y - 1);
            run_line(y);
            run_line(y + hl / 2);
            run_line(y + hl);
            run_line(y + hl + 1);
        end
        end_frame();
        end_test();

        begin_test("overlap");
        for (int k = 0; k < 6; k++) begin
            clear_scene();
            for (int j = 0; j < 8; j++) begin
                random_sprite(int'(rnd(7)), 300, 64);
            end
            run_line(300);
            run_line(302);
            run_line(305);
        end
        end_frame();
        end_test();

        begin_test("collisions");
        clear_scene();
        for (int j = 0; j < 6; j++) begin
            random_sprite(j * 3, 50, 200);
            attr_mem[6 * j + 1].hi.coll_mask = 4'(1 << (j % 4));
            attr_mem[6 * j + 1].hi.z         = 2'(j % 3 + 1);
        end
        for (int line = 50; line < 54; line++) begin
            run_line(line);
        end
        end_frame();
        // One masked sprite alone gives no collision
        clear_scene();
        random_sprite(10, 60, 100);
        attr_mem[21].hi.coll_mask = 4'd1;
        attr_mem[21].hi.z         = 2'd2;
        run_line(60);
        run_line(61);
        run_line(62);
        end_frame();
        end_test();

        begin_test("stress");
        clear_scene();
        for (int j = 0; j < 40; j++) begin
            random_sprite(int'(rnd(7)), 400, int'(rnd(10)));
        end
        for (int line = 400; line < 404; line++) begin
            run_line(line);
        end
        end_frame();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
